// File: logic/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath word
`define DATA_W 32

// Register file geometry
`define REG_COUNT 32
`define REG_SEL_W 5

`endif

// File: logic/isa_pkg.sv
package isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type, funct selects
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [5:0] {
        INSTR_ADDU, INSTR_SUBU, INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR,
        INSTR_SLT, INSTR_SLTU, INSTR_SLL, INSTR_SRL, INSTR_SRA, INSTR_JR, INSTR_JALR,
        INSTR_ADDIU, INSTR_SLTI, INSTR_ANDI, INSTR_ORI, INSTR_XORI, INSTR_LUI,
        INSTR_BEQ, INSTR_BNE,
        INSTR_LB, INSTR_LBU, INSTR_LH, INSTR_LHU, INSTR_LW,
        INSTR_SB, INSTR_SH, INSTR_SW,
        INSTR_J, INSTR_JAL,
        INSTR_ILLEGAL
    } instr_e;

endpackage

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI  // Shifts operand B up by 16
    } alu_op_e;

    typedef enum logic [2:0] {
        AGU_NONE,
        AGU_LOAD,
        AGU_STORE,
        AGU_BRANCH,
        AGU_JUMP_REG,
        AGU_JUMP_ABS
    } agu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS,
        SRC_A_RT,
        SRC_A_PC
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RT,
        SRC_B_IMM,
        SRC_B_SHAMT,
        SRC_B_FOUR  // Link adds 4 to PC+4
    } src_b_e;

    typedef enum logic {EXT_SIGN, EXT_ZERO} ext_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    typedef enum logic {WB_ALU, WB_MEM} wb_src_e;

endpackage

// File: logic/decode_if.sv
`include "decode_settings.svh"

interface decode_if;

    import isa_pkg::*;

    instr_e                 instr;   // Identified instruction
    logic [`REG_SEL_W-1:0]  rs;
    logic [`REG_SEL_W-1:0]  rt;
    logic [`REG_SEL_W-1:0]  rd;
    logic [4:0]             shamt;
    logic [15:0]            imm;     // Raw immediate before extension
    logic [25:0]            target;  // J-type index

    modport producer (output instr, rs, rt, rd, shamt, imm, target);

    modport consumer (input instr, rs, rt, rd, shamt, imm, target);

endinterface

// File: logic/instruction_decoder.sv
module instruction_decoder (
    input  logic [31:0]       i_instruction,
    decode_if.producer        dec
);

    import isa_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = i_instruction[31:26];
    assign funct  = i_instruction[5:0];

    // Field slicing is the same for all formats
    assign dec.rs     = i_instruction[25:21];
    assign dec.rt     = i_instruction[20:16];
    assign dec.rd     = i_instruction[15:11];
    assign dec.shamt  = i_instruction[10:6];
    assign dec.imm    = i_instruction[15:0];
    assign dec.target = i_instruction[25:0];

    always_comb begin
        dec.instr = INSTR_ILLEGAL;  // Anything unmatched
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:  dec.instr = INSTR_SLL;
                    FN_SRL:  dec.instr = INSTR_SRL;
                    FN_SRA:  dec.instr = INSTR_SRA;
                    FN_JR:   dec.instr = INSTR_JR;
                    FN_JALR: dec.instr = INSTR_JALR;
                    FN_ADDU: dec.instr = INSTR_ADDU;
                    FN_SUBU: dec.instr = INSTR_SUBU;
                    FN_AND:  dec.instr = INSTR_AND;
                    FN_OR:   dec.instr = INSTR_OR;
                    FN_XOR:  dec.instr = INSTR_XOR;
                    FN_NOR:  dec.instr = INSTR_NOR;
                    FN_SLT:  dec.instr = INSTR_SLT;
                    FN_SLTU: dec.instr = INSTR_SLTU;
                    default: dec.instr = INSTR_ILLEGAL;
                endcase
            end
            OP_J:     dec.instr = INSTR_J;
            OP_JAL:   dec.instr = INSTR_JAL;
            OP_BEQ:   dec.instr = INSTR_BEQ;
            OP_BNE:   dec.instr = INSTR_BNE;
            OP_ADDIU: dec.instr = INSTR_ADDIU;
            OP_SLTI:  dec.instr = INSTR_SLTI;
            OP_ANDI:  dec.instr = INSTR_ANDI;
            OP_ORI:   dec.instr = INSTR_ORI;
            OP_XORI:  dec.instr = INSTR_XORI;
            OP_LUI:   dec.instr = INSTR_LUI;
            OP_LB:    dec.instr = INSTR_LB;
            OP_LH:    dec.instr = INSTR_LH;
            OP_LW:    dec.instr = INSTR_LW;
            OP_LBU:   dec.instr = INSTR_LBU;
            OP_LHU:   dec.instr = INSTR_LHU;
            OP_SB:    dec.instr = INSTR_SB;
            OP_SH:    dec.instr = INSTR_SH;
            OP_SW:    dec.instr = INSTR_SW;
            default:  dec.instr = INSTR_ILLEGAL;
        endcase
    end

endmodule

// File: logic/control_unit.sv
`include "decode_settings.svh"

module control_unit (
    decode_if.consumer              dec,
    output ctrl_pkg::src_a_e        o_src_a,
    output ctrl_pkg::src_b_e        o_src_b,
    output ctrl_pkg::ext_e          o_ext,
    output ctrl_pkg::alu_op_e       o_alu_op,
    output ctrl_pkg::agu_op_e       o_agu_op,
    output logic                    o_branch,
    output logic                    o_branch_equal,
    output logic                    o_jump,
    output logic                    o_link,
    output ctrl_pkg::mem_size_e     o_mem_size,
    output logic                    o_mem_unsigned,
    output logic                    o_reg_wr_en,
    output logic                    o_mem_wr_en,
    output ctrl_pkg::wb_src_e       o_wb_src,
    output logic [`REG_SEL_W-1:0]   o_wb_reg,
    output logic                    o_illegal
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    // ALU operation per instruction
    always_comb begin
        case (dec.instr)
            INSTR_ADDU, INSTR_ADDIU, INSTR_JAL, INSTR_JALR: o_alu_op = ALU_ADD;
            INSTR_SUBU, INSTR_BEQ, INSTR_BNE:               o_alu_op = ALU_SUB;
            INSTR_AND, INSTR_ANDI:                          o_alu_op = ALU_AND;
            INSTR_OR, INSTR_ORI:                            o_alu_op = ALU_OR;
            INSTR_XOR, INSTR_XORI:                          o_alu_op = ALU_XOR;
            INSTR_NOR:                                      o_alu_op = ALU_NOR;
            INSTR_SLT, INSTR_SLTI:                          o_alu_op = ALU_SLT;
            INSTR_SLTU:                                     o_alu_op = ALU_SLTU;
            INSTR_SLL:                                      o_alu_op = ALU_SLL;
            INSTR_SRL:                                      o_alu_op = ALU_SRL;
            INSTR_SRA:                                      o_alu_op = ALU_SRA;
            INSTR_LUI:                                      o_alu_op = ALU_LUI;
            default:                                        o_alu_op = ALU_NONE;
        endcase
    end

    // Access width, also used by stores
    always_comb begin
        case (dec.instr)
            INSTR_LH, INSTR_LHU, INSTR_SH: o_mem_size = MEM_HALF;
            INSTR_LW, INSTR_SW:            o_mem_size = MEM_WORD;
            default:                       o_mem_size = MEM_BYTE;
        endcase
        o_mem_unsigned = (dec.instr == INSTR_LBU) || (dec.instr == INSTR_LHU);
    end

    always_comb begin
        o_src_a        = SRC_A_RS;
        o_src_b        = SRC_B_RT;
        o_ext          = EXT_SIGN;
        o_agu_op       = AGU_NONE;
        o_branch       = 1'b0;
        o_branch_equal = 1'b0;
        o_jump         = 1'b0;
        o_link         = 1'b0;
        o_reg_wr_en    = 1'b0;
        o_mem_wr_en    = 1'b0;
        o_wb_src       = WB_ALU;
        o_wb_reg       = '0;
        o_illegal      = 1'b0;
        case (dec.instr)
            INSTR_ADDU, INSTR_SUBU, INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR,
            INSTR_SLT, INSTR_SLTU: begin
                o_reg_wr_en = 1'b1;
                o_wb_reg    = dec.rd;
            end
            INSTR_SLL, INSTR_SRL, INSTR_SRA: begin
                o_src_a     = SRC_A_RT;     // Shift the rt value
                o_src_b     = SRC_B_SHAMT;
                o_reg_wr_en = 1'b1;
                o_wb_reg    = dec.rd;
            end
            INSTR_ADDIU, INSTR_SLTI: begin
                o_src_b     = SRC_B_IMM;
                o_reg_wr_en = 1'b1;
                o_wb_reg    = dec.rt;
            end
            INSTR_ANDI, INSTR_ORI, INSTR_XORI, INSTR_LUI: begin
                o_src_b     = SRC_B_IMM;
                o_ext       = EXT_ZERO;     // Logical immediates and LUI
                o_reg_wr_en = 1'b1;
                o_wb_reg    = dec.rt;
            end
            INSTR_BEQ, INSTR_BNE: begin
                o_agu_op       = AGU_BRANCH;
                o_branch       = 1'b1;
                o_branch_equal = (dec.instr == INSTR_BEQ);
            end
            INSTR_LB, INSTR_LBU, INSTR_LH, INSTR_LHU, INSTR_LW: begin
                o_agu_op    = AGU_LOAD;
                o_reg_wr_en = 1'b1;
                o_wb_src    = WB_MEM;
                o_wb_reg    = dec.rt;
            end
            INSTR_SB, INSTR_SH, INSTR_SW: begin
                o_agu_op    = AGU_STORE;
                o_mem_wr_en = 1'b1;
            end
            INSTR_J, INSTR_JR: begin
                o_agu_op = (dec.instr == INSTR_J) ? AGU_JUMP_ABS : AGU_JUMP_REG;
                o_jump   = 1'b1;
            end
            INSTR_JAL, INSTR_JALR: begin
                o_agu_op    = (dec.instr == INSTR_JAL) ? AGU_JUMP_ABS : AGU_JUMP_REG;
                o_jump      = 1'b1;
                o_link      = 1'b1;
                o_src_a     = SRC_A_PC;     // PC+4 plus 4 gives the return address
                o_src_b     = SRC_B_FOUR;
                o_reg_wr_en = 1'b1;
                o_wb_reg    = (dec.instr == INSTR_JAL) ? {`REG_SEL_W{1'b1}} : dec.rd;
            end
            default: begin
                o_illegal = 1'b1;           // Write enables stay low
            end
        endcase
    end

endmodule

// File: logic/register_file.sv
`include "decode_settings.svh"

module register_file (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [`REG_SEL_W-1:0]   i_rs_sel,
    input  logic [`REG_SEL_W-1:0]   i_rt_sel,
    input  logic [`REG_SEL_W-1:0]   i_wr_sel,
    input  logic                    i_wr_en,
    input  logic [`DATA_W-1:0]      i_wr_data,
    output logic [`DATA_W-1:0]      o_rs_data,
    output logic [`DATA_W-1:0]      o_rt_data
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_sel != '0)) begin  // r0 never written
            regs[i_wr_sel] <= i_wr_data;
        end
    end

    // No bypass, a write shows up next cycle
    assign o_rs_data = (i_rs_sel == '0) ? '0 : regs[i_rs_sel];
    assign o_rt_data = (i_rt_sel == '0) ? '0 : regs[i_rt_sel];

endmodule

// File: logic/operand_select.sv
`include "decode_settings.svh"

module operand_select (
    decode_if.consumer              dec,
    input  logic [`DATA_W-1:0]      i_pc,
    input  logic [`DATA_W-1:0]      i_rs_data,
    input  logic [`DATA_W-1:0]      i_rt_data,
    input  ctrl_pkg::src_a_e        i_src_a,
    input  ctrl_pkg::src_b_e        i_src_b,
    input  ctrl_pkg::ext_e          i_ext,
    input  ctrl_pkg::agu_op_e       i_agu_op,
    output logic [`DATA_W-1:0]      o_alu_src_a,
    output logic [`DATA_W-1:0]      o_alu_src_b,
    output logic [`DATA_W-1:0]      o_agu_base,
    output logic [25:0]             o_addr_offset,
    output logic [`DATA_W-1:0]      o_store_data
);

    import ctrl_pkg::*;

    logic [`DATA_W-1:0] imm_ext;
    logic [`DATA_W-1:0] shamt_ext;

    assign imm_ext = (i_ext == EXT_ZERO) ? {{(`DATA_W-16){1'b0}}, dec.imm}
                                         : {{(`DATA_W-16){dec.imm[15]}}, dec.imm};
    assign shamt_ext = {{(`DATA_W-5){1'b0}}, dec.shamt};

    always_comb begin
        case (i_src_a)
            SRC_A_RT: o_alu_src_a = i_rt_data;
            SRC_A_PC: o_alu_src_a = i_pc;
            default:  o_alu_src_a = i_rs_data;
        endcase
        case (i_src_b)
            SRC_B_IMM:   o_alu_src_b = imm_ext;
            SRC_B_SHAMT: o_alu_src_b = shamt_ext;
            SRC_B_FOUR:  o_alu_src_b = `DATA_W'(4);
            default:     o_alu_src_b = i_rt_data;
        endcase
    end

    // Branches are PC relative, everything else is based on rs
    assign o_agu_base = (i_agu_op == AGU_BRANCH) ? i_pc : i_rs_data;

    always_comb begin
        case (i_agu_op)
            AGU_LOAD, AGU_STORE, AGU_BRANCH: o_addr_offset = {{10{dec.imm[15]}}, dec.imm};
            AGU_JUMP_ABS:                    o_addr_offset = dec.target;
            default:                         o_addr_offset = '0;
        endcase
    end

    assign o_store_data = i_rt_data;

endmodule

// File: logic/decode_stage.sv
`include "decode_settings.svh"

module decode_stage (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [`DATA_W-1:0]      i_pc,           // Already PC+4
    input  logic [31:0]             i_instruction,
    input  logic                    i_wr_en,        // Writeback strobe
    input  logic [`REG_SEL_W-1:0]   i_wr_sel,
    input  logic [`DATA_W-1:0]      i_wr_data,
    output ctrl_pkg::alu_op_e       o_alu_op,
    output ctrl_pkg::agu_op_e       o_agu_op,
    output logic                    o_branch,
    output logic                    o_branch_equal,
    output logic                    o_jump,
    output logic                    o_link,
    output ctrl_pkg::mem_size_e     o_mem_size,
    output logic                    o_mem_unsigned,
    output logic                    o_reg_wr_en,
    output logic                    o_mem_wr_en,
    output ctrl_pkg::wb_src_e       o_wb_src,
    output logic                    o_illegal,
    output logic [`DATA_W-1:0]      o_alu_src_a,
    output logic [`DATA_W-1:0]      o_alu_src_b,
    output logic [`DATA_W-1:0]      o_agu_base,
    output logic [25:0]             o_addr_offset,
    output logic [`DATA_W-1:0]      o_store_data,
    output logic [`REG_SEL_W-1:0]   o_wb_reg
);

    import ctrl_pkg::*;

    decode_if dec ();

    src_a_e             src_a;
    src_b_e             src_b;
    ext_e               ext;
    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;

    instruction_decoder u_decoder (
        .i_instruction  (i_instruction),
        .dec            (dec.producer)
    );

    control_unit u_control (
        .dec            (dec.consumer),
        .o_src_a        (src_a),
        .o_src_b        (src_b),
        .o_ext          (ext),
        .o_alu_op       (o_alu_op),
        .o_agu_op       (o_agu_op),
        .o_branch       (o_branch),
        .o_branch_equal (o_branch_equal),
        .o_jump         (o_jump),
        .o_link         (o_link),
        .o_mem_size     (o_mem_size),
        .o_mem_unsigned (o_mem_unsigned),
        .o_reg_wr_en    (o_reg_wr_en),
        .o_mem_wr_en    (o_mem_wr_en),
        .o_wb_src       (o_wb_src),
        .o_wb_reg       (o_wb_reg),
        .o_illegal      (o_illegal)
    );

    register_file u_regs (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rs_sel       (dec.rs),
        .i_rt_sel       (dec.rt),
        .i_wr_sel       (i_wr_sel),
        .i_wr_en        (i_wr_en),
        .i_wr_data      (i_wr_data),
        .o_rs_data      (rs_data),
        .o_rt_data      (rt_data)
    );

    operand_select u_operands (
        .dec            (dec.consumer),
        .i_pc           (i_pc),
        .i_rs_data      (rs_data),
        .i_rt_data      (rt_data),
        .i_src_a        (src_a),
        .i_src_b        (src_b),
        .i_ext          (ext),
        .i_agu_op       (o_agu_op),
        .o_alu_src_a    (o_alu_src_a),
        .o_alu_src_b    (o_alu_src_b),
        .o_agu_base     (o_agu_base),
        .o_addr_offset  (o_addr_offset),
        .o_store_data   (o_store_data)
    );

endmodule

// File: tests/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Register file mirror, updated when the DUT captures a write
logic [`DATA_W-1:0] shadow [`REG_COUNT];

alu_op_e               exp_alu_op;
agu_op_e               exp_agu_op;
logic                  exp_branch;
logic                  exp_branch_equal;
logic                  exp_jump;
logic                  exp_link;
mem_size_e             exp_mem_size;
logic                  exp_mem_unsigned;
logic                  exp_reg_wr_en;
logic                  exp_mem_wr_en;
wb_src_e               exp_wb_src;
logic                  exp_illegal;
logic [`DATA_W-1:0]    exp_src_a;
logic [`DATA_W-1:0]    exp_src_b;
logic [`DATA_W-1:0]    exp_agu_base;
logic [25:0]           exp_offset;
logic [`DATA_W-1:0]    exp_store_data;
logic [`REG_SEL_W-1:0] exp_wb_reg;

function automatic logic [`DATA_W-1:0] reg_value(input logic [4:0] sel);
    return (sel == 5'd0) ? '0 : shadow[sel];  // r0 is hardwired
endfunction

// 1 R-type ALU, 2 immediate, 3 load or store, 4 branch or jump, 5 illegal
function automatic int instr_group(input logic [31:0] instr);
    case (instr[31:26])
        6'h00: begin
            case (instr[5:0])
                6'h00, 6'h02, 6'h03, 6'h21, 6'h23: return 1;
                6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B: return 1;
                6'h08, 6'h09: return 4;  // JR, JALR
                default: return 5;
            endcase
        end
        6'h09, 6'h0A, 6'h0C, 6'h0D, 6'h0E, 6'h0F: return 2;
        6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2B: return 3;
        6'h02, 6'h03, 6'h04, 6'h05: return 4;
        default: return 5;
    endcase
endfunction

function automatic alu_op_e rtype_alu(input logic [5:0] fn);
    case (fn)
        6'h21:   return ALU_ADD;
        6'h23:   return ALU_SUB;
        6'h24:   return ALU_AND;
        6'h25:   return ALU_OR;
        6'h26:   return ALU_XOR;
        6'h27:   return ALU_NOR;
        6'h2A:   return ALU_SLT;
        6'h2B:   return ALU_SLTU;
        6'h00:   return ALU_SLL;
        6'h02:   return ALU_SRL;
        default: return ALU_SRA;
    endcase
endfunction

// Return address is PC+4 plus 4
task automatic expect_link(input logic [`DATA_W-1:0] pc, input logic [4:0] dest);
    exp_link      = 1'b1;
    exp_alu_op    = ALU_ADD;
    exp_src_a     = pc;
    exp_src_b     = 32'd4;
    exp_reg_wr_en = 1'b1;
    exp_wb_reg    = dest;
endtask

task automatic predict(input logic [31:0] instr, input logic [`DATA_W-1:0] pc);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] sext;
    logic [31:0] zext;
    op     = instr[31:26];
    fn     = instr[5:0];
    rt     = instr[20:16];
    rd     = instr[15:11];
    rs_val = reg_value(instr[25:21]);
    rt_val = reg_value(rt);
    sext   = {{16{instr[15]}}, instr[15:0]};
    zext   = {16'h0000, instr[15:0]};
    exp_alu_op       = ALU_NONE;
    exp_agu_op       = AGU_NONE;
    exp_branch       = 1'b0;
    exp_branch_equal = 1'b0;
    exp_jump         = 1'b0;
    exp_link         = 1'b0;
    exp_mem_size     = MEM_BYTE;  // Idle width
    exp_mem_unsigned = 1'b0;
    exp_reg_wr_en    = 1'b0;
    exp_mem_wr_en    = 1'b0;
    exp_wb_src       = WB_ALU;
    exp_illegal      = 1'b0;
    exp_src_a        = rs_val;
    exp_src_b        = rt_val;
    exp_agu_base     = rs_val;
    exp_offset       = '0;
    exp_store_data   = rt_val;
    exp_wb_reg       = '0;
    case (instr_group(instr))
        1: begin
            exp_alu_op    = rtype_alu(fn);
            exp_reg_wr_en = 1'b1;
            exp_wb_reg    = rd;
            if (fn == 6'h00 || fn == 6'h02 || fn == 6'h03) begin
                exp_src_a = rt_val;  // Shift the rt value by shamt
                exp_src_b = {27'd0, instr[10:6]};
            end
        end
        2: begin
            exp_reg_wr_en = 1'b1;
            exp_wb_reg    = rt;
            exp_src_b     = (op >= 6'h0C) ? zext : sext;  // Logical ops and LUI zero extend
            case (op)
                6'h09:   exp_alu_op = ALU_ADD;
                6'h0A:   exp_alu_op = ALU_SLT;
                6'h0C:   exp_alu_op = ALU_AND;
                6'h0D:   exp_alu_op = ALU_OR;
                6'h0E:   exp_alu_op = ALU_XOR;
                default: exp_alu_op = ALU_LUI;
            endcase
        end
        3: begin
            exp_offset       = sext[25:0];
            exp_mem_unsigned = (op == 6'h24) || (op == 6'h25);
            case (op)
                6'h20, 6'h24, 6'h28: exp_mem_size = MEM_BYTE;
                6'h21, 6'h25, 6'h29: exp_mem_size = MEM_HALF;
                default:             exp_mem_size = MEM_WORD;
            endcase
            if (op >= 6'h28) begin
                exp_agu_op    = AGU_STORE;
                exp_mem_wr_en = 1'b1;
            end else begin
                exp_agu_op    = AGU_LOAD;
                exp_reg_wr_en = 1'b1;
                exp_wb_src    = WB_MEM;
                exp_wb_reg    = rt;
            end
        end
        4: begin
            if (op == 6'h04 || op == 6'h05) begin
                exp_agu_op       = AGU_BRANCH;
                exp_branch       = 1'b1;
                exp_branch_equal = (op == 6'h04);
                exp_alu_op       = ALU_SUB;  // Compare of rs and rt
                exp_agu_base     = pc;
                exp_offset       = sext[25:0];
            end else if (op == 6'h00) begin
                exp_agu_op = AGU_JUMP_REG;
                exp_jump   = 1'b1;
                if (fn == 6'h09) begin
                    expect_link(pc, rd);
                end
            end else begin
                exp_agu_op = AGU_JUMP_ABS;
                exp_jump   = 1'b1;
                exp_offset = instr[25:0];
                if (op == 6'h03) begin
                    expect_link(pc, 5'd31);
                end
            end
        end
        default: begin
            exp_illegal = 1'b1;
        end
    endcase
endtask

`endif

// File: tests/decode_stage_tb.sv
`include "decode_settings.svh"

module decode_stage_tb;

    import ctrl_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 3;
    localparam int REG_STEPS     = 232;  // 32 reads after reset, then random traffic
    localparam int GROUP_STEPS   = 150;
    localparam int TOTAL_STEPS   = REG_STEPS + 5 * GROUP_STEPS;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + TOTAL_STEPS + 20) * CLK_PERIOD;
    localparam int unsigned SEED = 32'h1887_1458;

    logic                  i_clk;
    logic                  i_reset;
    logic [`DATA_W-1:0]    i_pc;
    logic [31:0]           i_instruction;
    logic                  i_wr_en;
    logic [`REG_SEL_W-1:0] i_wr_sel;
    logic [`DATA_W-1:0]    i_wr_data;
    alu_op_e               o_alu_op;
    agu_op_e               o_agu_op;
    logic                  o_branch;
    logic                  o_branch_equal;
    logic                  o_jump;
    logic                  o_link;
    mem_size_e             o_mem_size;
    logic                  o_mem_unsigned;
    logic                  o_reg_wr_en;
    logic                  o_mem_wr_en;
    wb_src_e               o_wb_src;
    logic                  o_illegal;
    logic [`DATA_W-1:0]    o_alu_src_a;
    logic [`DATA_W-1:0]    o_alu_src_b;
    logic [`DATA_W-1:0]    o_agu_base;
    logic [25:0]           o_addr_offset;
    logic [`DATA_W-1:0]    o_store_data;
    logic [`REG_SEL_W-1:0] o_wb_reg;

    int test_errors;
    int test_checks;
    int tests_ok;
    int tests_bad;

    `include "decode_model.svh"

    decode_stage u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_pc           (i_pc),
        .i_instruction  (i_instruction),
        .i_wr_en        (i_wr_en),
        .i_wr_sel       (i_wr_sel),
        .i_wr_data      (i_wr_data),
        .o_alu_op       (o_alu_op),
        .o_agu_op       (o_agu_op),
        .o_branch       (o_branch),
        .o_branch_equal (o_branch_equal),
        .o_jump         (o_jump),
        .o_link         (o_link),
        .o_mem_size     (o_mem_size),
        .o_mem_unsigned (o_mem_unsigned),
        .o_reg_wr_en    (o_reg_wr_en),
        .o_mem_wr_en    (o_mem_wr_en),
        .o_wb_src       (o_wb_src),
        .o_illegal      (o_illegal),
        .o_alu_src_a    (o_alu_src_a),
        .o_alu_src_b    (o_alu_src_b),
        .o_agu_base     (o_agu_base),
        .o_addr_offset  (o_addr_offset),
        .o_store_data   (o_store_data),
        .o_wb_reg       (o_wb_reg)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        test_checks++;
        if (expected !== actual) begin
            test_errors++;
            $display("ERROR %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        compare("o_alu_op", 32'(exp_alu_op), 32'(o_alu_op));
        compare("o_agu_op", 32'(exp_agu_op), 32'(o_agu_op));
        compare("o_branch", 32'(exp_branch), 32'(o_branch));
        compare("o_branch_equal", 32'(exp_branch_equal), 32'(o_branch_equal));
        compare("o_jump", 32'(exp_jump), 32'(o_jump));
        compare("o_link", 32'(exp_link), 32'(o_link));
        compare("o_mem_size", 32'(exp_mem_size), 32'(o_mem_size));
        compare("o_mem_unsigned", 32'(exp_mem_unsigned), 32'(o_mem_unsigned));
        compare("o_reg_wr_en", 32'(exp_reg_wr_en), 32'(o_reg_wr_en));
        compare("o_mem_wr_en", 32'(exp_mem_wr_en), 32'(o_mem_wr_en));
        compare("o_wb_src", 32'(exp_wb_src), 32'(o_wb_src));
        compare("o_illegal", 32'(exp_illegal), 32'(o_illegal));
        compare("o_alu_src_a", exp_src_a, o_alu_src_a);
        compare("o_alu_src_b", exp_src_b, o_alu_src_b);
        compare("o_agu_base", exp_agu_base, o_agu_base);
        compare("o_addr_offset", 32'(exp_offset), 32'(o_addr_offset));
        compare("o_store_data", exp_store_data, o_store_data);
        compare("o_wb_reg", 32'(exp_wb_reg), 32'(o_wb_reg));
    endtask

    // Group 0 starts with reads of every register, then random R-type traffic
    function automatic logic [31:0] make_instruction(input int group, input int idx);
        logic [31:0] instr;
        if (group == 0 && idx < 32) begin
            return {6'h00, 5'(idx), 5'(31 - idx), 5'($urandom), 5'd0, 6'h21};
        end
        do begin
            instr = $urandom;
            if (group <= 1 || (group >= 4 && $urandom % 2 == 0)) begin
                instr[31:26] = 6'h00;  // SPECIAL, funct decides
            end
        end while (instr_group(instr) != ((group == 0) ? 1 : group));
        return instr;
    endfunction

    task automatic apply_step(input logic [31:0] instr, input bit allow_write);
        logic [`DATA_W-1:0]    pc;
        logic                  wr_en;
        logic [`REG_SEL_W-1:0] wr_sel;
        logic [`DATA_W-1:0]    wr_data;
        pc      = $urandom & 32'hFFFF_FFFC;
        wr_en   = allow_write && ($urandom % 2 == 0);
        wr_sel  = ($urandom % 8 == 0) ? 5'd0 : 5'($urandom);  // r0 writes now and then
        wr_data = $urandom;
        @(posedge i_clk);
        i_instruction <= instr;
        i_pc          <= pc;
        i_wr_en       <= wr_en;
        i_wr_sel      <= wr_sel;
        i_wr_data     <= wr_data;
        @(negedge i_clk);
        predict(instr, pc);
        check_outputs();
        if (wr_en && wr_sel != 5'd0) begin
            shadow[wr_sel] = wr_data;  // Captured at the next rising edge
        end
    endtask

    task automatic run_test(input string name, input int group, input int steps);
        test_errors = 0;
        test_checks = 0;
        for (int i = 0; i < steps; i++) begin
            apply_step(make_instruction(group, i), !(group == 0 && i < 32));
        end
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok, %0d checks", name, test_checks);
        end else begin
            tests_bad++;
            $display("%s: FAILED, %0d of %0d checks wrong", name, test_errors, test_checks);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_pc          = '0;
        i_instruction = '0;
        i_wr_en       = 1'b0;
        i_wr_sel      = '0;
        i_wr_data     = '0;
        shadow        = '{default: '0};
        tests_ok      = 0;
        tests_bad     = 0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        run_test("register file", 0, REG_STEPS);
        run_test("r-type alu", 1, GROUP_STEPS);
        run_test("immediate", 2, GROUP_STEPS);
        run_test("load and store", 3, GROUP_STEPS);
        run_test("branch and jump", 4, GROUP_STEPS);
        run_test("illegal encoding", 5, GROUP_STEPS);
        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog: stimulus did not finish within %0d time units", WATCHDOG_TIME);
        $display("test failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+logic
+incdir+tests
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/decode_if.sv
logic/instruction_decoder.sv
logic/control_unit.sv
logic/register_file.sv
logic/operand_select.sv
logic/decode_stage.sv
tests/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
FILELIST  ?= project.f
TOP       ?= decode_stage_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
